//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module warpFsb_tb
	./obj_dir/VwarpFsb_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- rtl/dramCtrl.sv
`timescale 1ns/1ps

module dramCtrl (
	input  logic           clkFsb,
	input  logic           rst,
	input  fsbPkg::fsbReq  req,
	input  logic           bact,
	input  fsbPkg::devSel  sel,
	input  logic           fastRomEn,
	input  logic           refReq,
	input  logic           refUrgent,
	output logic           refAck,
	output logic           readyMem,
	output fsbPkg::dramBus mem
);

	typedef enum logic [2:0] {
		stIdle,
		stRow,
		stCol,
		stAccess,
		stRefCas,
		stRefRas,
		stRomWait
	} memState;

	memState                       state;
	logic [fsbPkg::ROM_CNT_W-1:0]  waitCnt; // ROM wait and refresh hold count
	logic [fsbPkg::RA_W-1:0]       rowAddr;
	logic [fsbPkg::RA_W-1:0]       colAddr;
	logic                          cycStart; // Strobe seen, decode not ready yet
	logic                          ramGo;
	logic                          romGo;
	logic                          doRef;
	logic                          busEnd; // CPU released strobe

	assign rowAddr  = {1'b0, req.addr[21:11]};
	assign colAddr  = {2'b00, req.addr[10:1]};
	assign cycStart = ~req.nAs & ~bact;
	assign ramGo    = bact & sel.ram & ~req.nAs;
	assign romGo    = bact & sel.rom & ~req.nAs;
	// Urgent refresh wins, otherwise memory cycles go first
	assign doRef    = refReq & (refUrgent | (~ramGo & ~romGo & ~cycStart));
	assign busEnd   = req.nAs & (state inside {stRow, stCol, stAccess, stRomWait});

	always_ff @(posedge clkFsb) begin
		if (rst) begin
			state       <= stIdle;
			waitCnt     <= '0;
			refAck      <= 1'b0;
			readyMem    <= 1'b0;
			mem.ra      <= '0;
			mem.nRas    <= 1'b1;
			mem.nCas    <= 1'b1;
			mem.nRamLwe <= 1'b1;
			mem.nRamUwe <= 1'b1;
			mem.nOe     <= 1'b1;
			mem.nRomCs  <= 1'b1;
		end else begin
			refAck <= 1'b0; // Single pulse per refresh
			if (busEnd) begin
				state       <= stIdle; // All strobes released together
				readyMem    <= 1'b0;
				mem.ra      <= rowAddr;
				mem.nRas    <= 1'b1;
				mem.nCas    <= 1'b1;
				mem.nRamLwe <= 1'b1;
				mem.nRamUwe <= 1'b1;
				mem.nOe     <= 1'b1;
				mem.nRomCs  <= 1'b1;
			end else begin
				case (state)
					stIdle: begin
						mem.ra <= rowAddr; // Row sits on ra ahead of RAS
						if (doRef) begin
							mem.nCas <= 1'b0; // CAS before RAS
							refAck   <= 1'b1;
							state    <= stRefCas;
						end else if (ramGo) begin
							mem.nRas <= 1'b0;
							mem.nOe  <= ~req.nWe; // Read only
							state    <= stRow;
						end else if (romGo) begin
							mem.nRomCs <= 1'b0;
							mem.nOe    <= ~req.nWe;
							waitCnt    <= fastRomEn ? fsbPkg::ROM_FAST_LOAD : fsbPkg::ROM_SLOW_LOAD;
							state      <= stRomWait;
						end
					end
					stRow: begin
						mem.ra <= colAddr; // Switch to column
						state  <= stCol;
					end
					stCol: begin
						mem.nCas <= 1'b0;
						readyMem <= 1'b1;
						if (!req.nWe) begin
							mem.nRamLwe <= req.nLds; // Byte lanes from data strobes
							mem.nRamUwe <= req.nUds;
						end
						state <= stAccess;
					end
					stAccess: begin
						state <= stAccess; // Held until nAs rises
					end
					stRefCas: begin
						mem.nRas <= 1'b0;
						waitCnt  <= fsbPkg::REF_HOLD;
						state    <= stRefRas;
					end
					stRefRas: begin
						if (waitCnt == '0) begin
							mem.nRas <= 1'b1; // Refresh done, precharge
							mem.nCas <= 1'b1;
							mem.ra   <= rowAddr;
							state    <= stIdle;
						end else begin
							waitCnt <= waitCnt - 1'b1;
						end
					end
					stRomWait: begin
						if (waitCnt == '0)
							readyMem <= 1'b1; // Wait states done
						else
							waitCnt <= waitCnt - 1'b1;
					end
					default: state <= stIdle;
				endcase
			end
		end
	end

endmodule

//--- rtl/fsbAck.sv
`timescale 1ns/1ps

module fsbAck (
	input  logic          clkFsb,
	input  logic          rst,
	input  fsbPkg::fsbReq req,
	input  logic          bact,
	input  fsbPkg::devSel sel,
	input  logic          readyMem,
	input  logic          ioReady,
	input  logic          berrTimeout,
	output logic          nDtack,
	output logic          nVpa,
	output logic          nBerr
);

	logic ioReadyQ; // Sampled level from the I/O agent
	logic ready;    // Ready from the selected target
	logic berrHit;

	assign ready = ((sel.ram | sel.rom) & readyMem) | (sel.io & ioReadyQ);
	// I/O waits on its agent, never times out
	assign berrHit = berrTimeout & ~sel.io & ~ready;

	always_ff @(posedge clkFsb) begin
		if (rst) begin
			ioReadyQ <= 1'b0;
			nDtack   <= 1'b1;
			nVpa     <= 1'b1;
			nBerr    <= 1'b1;
		end else begin
			ioReadyQ <= ioReady;
			if (req.nAs) begin
				nDtack <= 1'b1; // Released once the CPU drops nAs
				nVpa   <= 1'b1;
				nBerr  <= 1'b1;
			end else if (bact) begin
				if (ready && nVpa && nBerr)
					nDtack <= 1'b0;
				if (sel.iack && nDtack && nBerr)
					nVpa <= 1'b0; // Autovector
				if (berrHit && nDtack && nVpa)
					nBerr <= 1'b0;
			end
		end
	end

endmodule

//--- rtl/fsbCounter.sv
`timescale 1ns/1ps

module fsbCounter (
	input  logic       clkFsb,
	input  logic       rst,
	input  logic       bact,
	input  logic       lbact,
	input  logic       refAck,
	input  logic [3:1] sw,
	output logic       refReq,
	output logic       refUrgent,
	output logic       berrTimeout,
	output logic       fastRomEn
);

	logic [fsbPkg::REF_CNT_W-1:0]  refCnt;  // Free running interval
	logic [fsbPkg::REF_AGE_W-1:0]  refAge;  // Cycles the request has waited
	logic [fsbPkg::BERR_CNT_W-1:0] berrCnt; // Cycles of the current bus cycle
	logic                          refTick;

	assign refTick = (refCnt == fsbPkg::REF_LAST);

	// Refresh interval and request aging
	always_ff @(posedge clkFsb) begin
		if (rst) begin
			refCnt    <= '0;
			refAge    <= '0;
			refReq    <= 1'b0;
			refUrgent <= 1'b0;
		end else begin
			refCnt <= refTick ? '0 : refCnt + 1'b1;
			refReq <= refTick | (refReq & ~refAck); // Held until served
			if (!refReq || refAck) begin
				refAge    <= '0;
				refUrgent <= 1'b0;
			end else if (refAge == fsbPkg::REF_AGE_LAST) begin
				refUrgent <= 1'b1;
			end else begin
				refAge <= refAge + 1'b1;
			end
		end
	end

	// Bus error timeout
	always_ff @(posedge clkFsb) begin
		if (rst || !bact)
			berrCnt <= '0;
		else if (!lbact)
			berrCnt <= fsbPkg::BERR_CNT_W'(1); // First active cycle
		else if (berrCnt != fsbPkg::BERR_MAX)
			berrCnt <= berrCnt + 1'b1; // Saturates
	end

	assign berrTimeout = (berrCnt == fsbPkg::BERR_MAX);

	// Switch sampled only under reset
	always_ff @(posedge clkFsb) begin
		if (rst)
			fastRomEn <= sw[1];
	end

endmodule

//--- rtl/fsbPkg.sv
package fsbPkg;

	// Address map in byte addresses
	localparam logic [23:0] RAM_TOP   = 24'h3FFFFF; // RAM 0x000000 to here
	localparam logic [23:0] ROM_BASE  = 24'h400000; // ROM up to IO_BASE
	localparam logic [23:0] IO_BASE   = 24'h500000; // I/O space start
	localparam logic [23:0] IO_TOP    = 24'hEFFFFF; // I/O space end
	localparam logic [23:0] IACK_BASE = 24'hFF0000; // Interrupt acknowledge space
	// 0xF00000 to 0xFEFFFF decodes as unmapped

	// Cycle timing
	localparam int REF_PERIOD    = 60; // Refresh interval in cycles
	localparam int REF_URGENT    = 30; // Pending age before urgent
	localparam int BERR_CYCLES   = 32; // Bus error timeout
	localparam int ROM_FAST_WAIT = 1;  // Fast ROM wait states
	localparam int ROM_SLOW_WAIT = 4;  // Slow ROM wait states

	// Counter widths
	localparam int REF_CNT_W  = $clog2(REF_PERIOD);
	localparam int REF_AGE_W  = $clog2(REF_URGENT);
	localparam int BERR_CNT_W = $clog2(BERR_CYCLES + 1);
	localparam int ROM_CNT_W  = $clog2(ROM_SLOW_WAIT + 1);
	localparam int RA_W       = 12; // DRAM multiplexed address width

	// Terminal and load values, sized to their counters
	localparam logic [REF_CNT_W-1:0]  REF_LAST      = REF_CNT_W'(REF_PERIOD - 1);
	localparam logic [REF_AGE_W-1:0]  REF_AGE_LAST  = REF_AGE_W'(REF_URGENT - 1);
	localparam logic [BERR_CNT_W-1:0] BERR_MAX      = BERR_CNT_W'(BERR_CYCLES);
	localparam logic [ROM_CNT_W-1:0]  ROM_FAST_LOAD = ROM_CNT_W'(ROM_FAST_WAIT - 1);
	localparam logic [ROM_CNT_W-1:0]  ROM_SLOW_LOAD = ROM_CNT_W'(ROM_SLOW_WAIT - 1);
	localparam logic [ROM_CNT_W-1:0]  REF_HOLD      = ROM_CNT_W'(1); // Extra RAS low cycle

	// CPU side of the front side bus
	typedef struct packed {
		logic [23:1] addr; // Word address
		logic        nAs;  // Address strobe
		logic        nUds; // Upper data strobe
		logic        nLds; // Lower data strobe
		logic        nWe;  // Low for write
	} fsbReq;

	// One-hot cycle target
	typedef struct packed {
		logic ram;
		logic rom;
		logic io;
		logic iack;
		logic none; // Unmapped space
	} devSel;

	// DRAM and ROM pins
	typedef struct packed {
		logic [RA_W-1:0] ra; // Row or column address
		logic            nRas;
		logic            nCas;
		logic            nRamLwe; // Low byte write enable
		logic            nRamUwe; // High byte write enable
		logic            nOe;     // Shared output enable
		logic            nRomCs;
	} dramBus;

endpackage

//--- rtl/selDecode.sv
`timescale 1ns/1ps

module selDecode (
	input  logic          clkFsb,
	input  logic          rst,
	input  fsbPkg::fsbReq req,
	output logic          bact,
	output logic          lbact,
	output fsbPkg::devSel sel
);

	logic [23:0]   byteAddr; // Byte address from word address
	fsbPkg::devSel decSel;   // Target for the current address

	assign byteAddr = {req.addr, 1'b0};

	// Address map decode, exactly one field set
	always_comb begin
		decSel = '0;
		if (byteAddr <= fsbPkg::RAM_TOP)
			decSel.ram = 1'b1;
		else if (byteAddr >= fsbPkg::ROM_BASE && byteAddr < fsbPkg::IO_BASE)
			decSel.rom = 1'b1;
		else if (byteAddr >= fsbPkg::IO_BASE && byteAddr <= fsbPkg::IO_TOP)
			decSel.io = 1'b1;
		else if (byteAddr >= fsbPkg::IACK_BASE)
			decSel.iack = 1'b1;
		else
			decSel.none = 1'b1; // Gap below IACK space
	end

	always_ff @(posedge clkFsb) begin
		if (rst) begin
			bact  <= 1'b0;
			lbact <= 1'b0;
			sel   <= '0;
		end else begin
			bact  <= ~req.nAs; // Cycle active while strobe held
			lbact <= bact;     // One cycle late copy
			if (req.nAs)
				sel <= '0; // Cleared with bact
			else if (!bact)
				sel <= decSel; // Captured once at cycle start
		end
	end

endmodule

//--- rtl/warpFsb.sv
`timescale 1ns/1ps

module warpFsb (
	input  logic           clkFsb,
	input  logic           rst,
	input  fsbPkg::fsbReq  req,
	input  logic [3:1]     sw,
	input  logic           ioReady,
	output fsbPkg::dramBus mem,
	output logic           nDtack,
	output logic           nVpa,
	output logic           nBerr
);

	logic          bact;        // Bus cycle active
	logic          lbact;       // Delayed bact
	fsbPkg::devSel sel;         // Registered target
	logic          refReq;
	logic          refUrgent;
	logic          refAck;
	logic          fastRomEn;   // Latched config switch
	logic          berrTimeout;
	logic          readyMem;    // RAM or ROM data ready

	selDecode selDecode_i (
		.clkFsb (clkFsb),
		.rst    (rst),
		.req    (req),
		.bact   (bact),
		.lbact  (lbact),
		.sel    (sel)
	);

	dramCtrl dramCtrl_i (
		.clkFsb    (clkFsb),
		.rst       (rst),
		.req       (req),
		.bact      (bact),
		.sel       (sel),
		.fastRomEn (fastRomEn),
		.refReq    (refReq),
		.refUrgent (refUrgent),
		.refAck    (refAck),
		.readyMem  (readyMem),
		.mem       (mem)
	);

	fsbCounter fsbCounter_i (
		.clkFsb      (clkFsb),
		.rst         (rst),
		.bact        (bact),
		.lbact       (lbact),
		.refAck      (refAck),
		.sw          (sw),
		.refReq      (refReq),
		.refUrgent   (refUrgent),
		.berrTimeout (berrTimeout),
		.fastRomEn   (fastRomEn)
	);

	fsbAck fsbAck_i (
		.clkFsb      (clkFsb),
		.rst         (rst),
		.req         (req),
		.bact        (bact),
		.sel         (sel),
		.readyMem    (readyMem),
		.ioReady     (ioReady),
		.berrTimeout (berrTimeout),
		.nDtack      (nDtack),
		.nVpa        (nVpa),
		.nBerr       (nBerr)
	);

endmodule

//--- tests/warpFsb_properties.sv
`timescale 1ns/1ps

module warpFsb_properties (
	input logic           clkFsb,
	input logic           rst,
	input fsbPkg::fsbReq  req,
	input logic [2:0]     ack,    // nDtack, nVpa, nBerr
	input fsbPkg::dramBus mem,
	input logic           refAck  // High on the refresh CAS edge
);

	// Access CAS only after RAS
	casAfterRas: assert property (@(posedge clkFsb) disable iff (rst)
		($fell(mem.nCas) && !refAck) |-> (!mem.nRas && !$past(mem.nRas)))
		else $error("CAS fell without RAS low");

	ackOneHot: assert property (@(posedge clkFsb) disable iff (rst)
		$onehot0(~ack))
		else $error("More than one acknowledge low");

	// Release one cycle after the CPU drops nAs
	releaseAll: assert property (@(posedge clkFsb) disable iff (rst)
		$rose(req.nAs) |=> (&ack && mem.nOe && mem.nRomCs && mem.nRamLwe && mem.nRamUwe))
		else $error("Strobes not released after nAs rose");

endmodule

bind dramCtrl warpFsb_properties memProps_i (
	.clkFsb (clkFsb),
	.rst    (rst),
	.req    (req),
	.ack    (3'b111),
	.mem    (mem),
	.refAck (refAck)
);

bind fsbAck warpFsb_properties ackProps_i (
	.clkFsb (clkFsb),
	.rst    (rst),
	.req    (req),
	.ack    ({nDtack, nVpa, nBerr}),
	.mem    ({12'h000, 6'h3F}),
	.refAck (1'b0)
);

//--- tests/warpFsb_tb.sv
`timescale 1ns/1ps

module warpFsb_tb;

	typedef enum logic [1:0] {ackDtack, ackVpa, ackBerr, ackNone} ackKind;

	typedef struct packed {
		ackKind     kind;
		logic [7:0] lo;  // Latency bound after edge k
		logic [7:0] hi;
		logic [11:0] row;
		logic [11:0] col;
		logic       memDev; // RAM or ROM target
		logic       rom;
	} ackExp;

	logic           clkFsb = 1'b0;
	logic           rst;
	fsbPkg::fsbReq  req;
	logic [3:1]     sw;
	logic           ioReady;
	fsbPkg::dramBus mem;
	logic           nDtack;
	logic           nVpa;
	logic           nBerr;

	logic [31:0] lfsr = 32'hb0ce;
	logic        fastSw;  // Switch level latched by the last reset
	int          errors = 0;
	int          checks = 0;
	string       testName;
	ackExp       expRes;  // Expected response of the last cycle
	ackKind      obsKind; // Observed response
	int          obsLat;
	event        resultEv;

	warpFsb dut_i (
		.clkFsb  (clkFsb),
		.rst     (rst),
		.req     (req),
		.sw      (sw),
		.ioReady (ioReady),
		.mem     (mem),
		.nDtack  (nDtack),
		.nVpa    (nVpa),
		.nBerr   (nBerr)
	);

	always #20 clkFsb = ~clkFsb; // 40 ns period

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr); // One step per bit
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	// Expected response from the address map and cycle timing rules
	function automatic ackExp expectAck(input logic [23:1] addr, input logic fast,
		input int ioDelay);
		ackExp       e;
		logic [23:0] byteAddr;
		byteAddr = {addr, 1'b0};
		e.row = {1'b0, addr[21:11]};
		e.col = {2'b00, addr[10:1]};
		e.memDev = 1'b0;
		e.rom    = 1'b0;
		if (byteAddr <= 24'h3FFFFF) begin
			e.kind   = ackDtack;
			e.lo     = 8'd4;
			e.hi     = 8'd8; // Refresh may stretch it
			e.memDev = 1'b1;
		end else if (byteAddr < 24'h500000) begin
			e.kind   = ackDtack;
			e.lo     = fast ? 8'd3 : 8'd6;
			e.hi     = e.lo;
			e.memDev = 1'b1;
			e.rom    = 1'b1;
		end else if (byteAddr < 24'hF00000) begin
			e.kind = ackDtack;
			e.lo   = 8'(ioDelay + 2); // Sampled, then registered
			e.hi   = e.lo;
		end else if (byteAddr >= 24'hFF0000) begin
			e.kind = ackVpa;
			e.lo   = 8'd1;
			e.hi   = 8'd1;
		end else begin
			e.kind = ackBerr;
			e.lo   = 8'd33; // Timeout plus one
			e.hi   = 8'd33;
		end
		return e;
	endfunction

	task automatic checkVal(input string name, input int exp, input int act);
		checks++;
		assert (exp == act) else begin
			errors++;
			$display("[ERROR] %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	// Compares each finished cycle against the reference
	always begin
		@(resultEv);
		checkVal({testName, " response"}, 32'(expRes.kind), 32'(obsKind));
		checks++;
		assert (obsLat >= int'(expRes.lo) && obsLat <= int'(expRes.hi)) else begin
			errors++;
			$display("[ERROR] %s latency expected %0d..%0d actual %0d", testName,
				expRes.lo, expRes.hi, obsLat);
		end
	end

	task automatic doReset(input logic fast);
		@(posedge clkFsb);
		rst <= 1'b1;
		sw  <= {2'b00, fast}; // Changed only under reset
		fastSw = fast;
		for (int i = 0; i < 4; i++) begin
			@(posedge clkFsb); // Reset sampled high here
			if (i == 3)
				rst <= 1'b0;
			@(negedge clkFsb);
			checkVal("reset strobes", 32'hF, 32'({nDtack, nVpa, nBerr, mem.nRas}));
			checkVal("reset mem", 32'h1F, 32'({mem.nCas, mem.nRamLwe, mem.nRamUwe, mem.nOe,
				mem.nRomCs}));
		end
	endtask

	// Lines the next cycle up just after a refresh ends
	task automatic syncRefresh();
		int t;
		t = 0;
		while (mem.nCas && t < 100) begin
			@(negedge clkFsb);
			t++;
		end
		while ((!mem.nCas || !mem.nRas) && t < 110) begin
			@(negedge clkFsb);
			t++;
		end
		if (t >= 100) begin
			errors++;
			$display("Timeout: no refresh seen before %s", testName);
		end
	endtask

	task automatic busCycle(input logic [23:1] addr, input logic nWe, input logic [1:0] lanes,
		input int ioDelay);
		int   i;
		int   t;
		logic prevRas;
		logic prevCas;
		expRes = expectAck(addr, fastSw, ioDelay);
		@(posedge clkFsb);
		req <= '{addr: addr, nAs: 1'b0, nUds: lanes[1], nLds: lanes[0], nWe: nWe};
		prevRas = 1'b1;
		prevCas = 1'b1;
		i = -1;
		while (nDtack && nVpa && nBerr && i < 100) begin
			@(posedge clkFsb); // Edge k + i + 1
			if (i + 1 == ioDelay)
				ioReady <= 1'b1;
			@(negedge clkFsb);
			i++;
			if (prevRas && !mem.nRas && mem.nCas)
				checkVal({testName, " row"}, 32'(expRes.row), 32'(mem.ra));
			if (prevCas && !mem.nCas && !mem.nRas) begin
				checkVal({testName, " column"}, 32'(expRes.col), 32'(mem.ra));
				checkVal({testName, " lwe"}, 32'(nWe ? 1'b1 : lanes[0]), 32'(mem.nRamLwe));
				checkVal({testName, " uwe"}, 32'(nWe ? 1'b1 : lanes[1]), 32'(mem.nRamUwe));
			end
			prevRas = mem.nRas;
			prevCas = mem.nCas;
		end
		// Output enable for memory reads, chip select for ROM only
		checkVal({testName, " oe"}, 32'(!(expRes.memDev && nWe)), 32'(mem.nOe));
		checkVal({testName, " rom cs"}, 32'(!expRes.rom), 32'(mem.nRomCs));
		obsKind = !nDtack ? ackDtack : !nVpa ? ackVpa : !nBerr ? ackBerr : ackNone;
		obsLat  = i;
		if (obsKind == ackNone) begin
			errors++;
			$display("Timeout: no acknowledge for %s", testName);
		end
		-> resultEv;
		@(posedge clkFsb);
		req     <= '{addr: addr, nAs: 1'b1, nUds: 1'b1, nLds: 1'b1, nWe: 1'b1};
		ioReady <= 1'b0;
		t = 0;
		while ((!nDtack || !nVpa || !nBerr) && t < 10) begin
			@(negedge clkFsb);
			t++;
		end
		if (t >= 10) begin
			errors++;
			$display("Timeout: acknowledge stuck low after %s", testName);
		end
		repeat (2) @(posedge clkFsb);
	endtask

	initial begin
		int refCount;
		logic prevCas;
		logic [1:0] lanes;
		rst     = 1'b1;
		sw      = 3'b001;
		ioReady = 1'b0;
		req     = '{addr: '0, nAs: 1'b1, nUds: 1'b1, nLds: 1'b1, nWe: 1'b1};
		fastSw  = 1'b1;
		testName = "reset";
		doReset(1'b1);
		repeat (3) begin
			@(negedge clkFsb);
			checkVal("idle strobes", 32'hF, 32'({nDtack, nVpa, nBerr, mem.nRas}));
		end
		testName = "ram";
		repeat (12) begin
			lanes = 2'(randBits(2));
			if (lanes == 2'b11)
				lanes = 2'b00; // Writes use at least one lane
			busCycle({2'b00, 21'(randBits(21))}, 1'(randBits(1)), lanes, -1);
		end
		testName = "rom fast";
		syncRefresh();
		busCycle({4'h4, 19'(randBits(19))}, 1'b1, 2'b00, -1);
		doReset(1'b0);
		testName = "rom slow";
		syncRefresh();
		busCycle({4'h4, 19'(randBits(19))}, 1'b1, 2'b00, -1);
		testName = "io";
		busCycle({4'h5 + 4'(randBits(3)), 19'(randBits(19))}, 1'b1, 2'b00, 40); // Past timeout
		repeat (3)
			busCycle({4'h5 + 4'(randBits(3)), 19'(randBits(19))}, 1'(randBits(1)), 2'b00,
				randBits(6));
		testName = "iack";
		syncRefresh();
		busCycle({8'hFF, 15'(randBits(15))}, 1'b1, 2'b00, -1);
		testName = "unmapped";
		busCycle({5'b11110, 18'(randBits(18))}, 1'b1, 2'b00, -1);
		testName = "refresh";
		refCount = 0;
		prevCas  = mem.nCas;
		repeat (600) begin
			@(negedge clkFsb);
			if (prevCas && !mem.nCas && mem.nRas)
				refCount++; // CAS before RAS
			prevCas = mem.nCas;
		end
		checks++;
		assert (refCount >= 9 && refCount <= 11) else begin
			errors++;
			$display("[ERROR] refresh count expected 9..11 actual %0d", refCount);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- verilog.f
rtl/fsbPkg.sv
rtl/selDecode.sv
rtl/dramCtrl.sv
rtl/fsbCounter.sv
rtl/fsbAck.sv
rtl/warpFsb.sv
tests/warpFsb_properties.sv
tests/warpFsb_tb.sv
